// File: dv/cache_checker.sv
`include "cache_defs.svh"

module cache_checker
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  cpu_req_t  req,
    input  logic      addr_ok,
    input  logic      data_ok,
    input  word_t     rdata,
    input  logic      rd_req,
    input  mem_addr_t rd_addr,
    input  logic      wr_req,
    input  mem_addr_t wr_addr,
    input  line_t     wr_data,
    input  logic      in_idle,
    input  logic      conflict,
    output int        error_count,
    output int        check_count,
    output int        pending
);

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        op;
        mem_addr_t   addr;
        word_t       expect_data;
        logic [31:0] acc_cycle;
    } pending_t;

    word_t       shadow [mem_addr_t];   // only words touched by stores
    pending_t    pend_q [$];
    pending_t    head;
    cpu_req_t    last_acc;              // request that owns the miss walk
    mem_addr_t   req_addr;
    logic [31:0] cycle;
    logic        first_cycle;
    logic        walk_seen;             // rd_req seen since the last acceptance

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
    end

    function automatic word_t shadow_word(input mem_addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ 32'h5a5a0000;   // untouched memory pattern
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t strb);
        word_t res;
        res = old_w;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                res[8*k +: 8] = new_w[8*k +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        check_count++;
        if (ok !== 1'b1) begin
            error_count++;
            $display("%0t: %s", $time, what);
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            first_cycle = 1'b1;
            walk_seen   = 1'b0;
            cycle       = '0;
            pend_q.delete();
            pending     = 0;
        end else begin
            cycle = cycle + 1;
            if (first_cycle) begin
                check_rule(!data_ok && !rd_req && !wr_req,
                           "data_ok, rd_req or wr_req was high right after reset");
                first_cycle = 1'b0;
            end
            if (valid && in_idle && !conflict) begin
                check_rule(addr_ok, "addr_ok stayed low for a request in IDLE without conflict");
            end
            // completions belong to older requests and are popped first
            if (data_ok) begin
                if (pend_q.size() == 0) begin
                    check_rule(1'b0, "data_ok arrived with no request outstanding");
                end else begin
                    head = pend_q.pop_front();
                    if (head.op) begin
                        compare_value("store_latency", head.acc_cycle + 1, cycle);
                    end else begin
                        compare_value("load_data", head.expect_data, rdata);
                        if (!walk_seen) begin
                            compare_value("hit_latency", head.acc_cycle + 1, cycle);
                        end
                    end
                end
            end
            if (wr_req) begin
                check_rule(wr_addr[3:0] == 4'h0, "wr_addr is not line aligned");
                for (int b = 0; b < `CACHE_BANKS; b++) begin
                    compare_value("wr_data", shadow_word({wr_addr[31:4], bank_sel_t'(b), 2'b00}),
                                  wr_data[b*`WORD_W +: `WORD_W]);
                end
            end
            if (rd_req) begin
                compare_value("rd_addr", {last_acc.tag, last_acc.index, 4'h0}, rd_addr);
                walk_seen = 1'b1;
            end
            if (valid && addr_ok) begin
                req_addr  = {req.tag, req.index, req.offset[3:2], 2'b00};
                last_acc  = req;
                walk_seen = 1'b0;
                if (req.op) begin
                    shadow[req_addr] = merge_bytes(shadow_word(req_addr), req.wdata, req.wstrb);
                end
                pend_q.push_back('{op: req.op, addr: req_addr,
                                   expect_data: shadow_word(req_addr), acc_cycle: cycle});
            end
            pending = pend_q.size();
        end
    end

endmodule

// File: dv/tb_cache.sv
`include "cache_defs.svh"

module tb_cache
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ        = 2000;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 60;

    logic      clk;
    logic      resetn;
    logic      valid;
    logic      op;
    index_t    index;
    tag_t      tag;
    offset_t   offset;
    strb_t     wstrb;
    word_t     wdata;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      rd_req;
    mem_addr_t rd_addr;
    logic      rd_rdy;
    logic      ret_valid;
    logic      ret_last;
    word_t     ret_data;
    logic      wr_req;
    mem_addr_t wr_addr;
    line_t     wr_data;
    logic      wr_rdy;

    integer      seed;
    logic [31:0] r;
    int          cycle_count = 0;
    int          error_count;
    int          check_count;
    int          pending;
    cpu_req_t    mon_req;
    word_t       mem [mem_addr_t];   // written back lines only

    cache_top u_dut (.*);

    assign mon_req = '{op: op, index: index, tag: tag, offset: offset, wstrb: wstrb, wdata: wdata};

    cache_checker u_checker (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (mon_req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .in_idle     (u_dut.u_ctrl.state == IDLE),
        .conflict    (u_dut.conflict),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    function automatic word_t mem_word(input mem_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'h5a5a0000;
    endfunction

    // four beats with random gaps, starting right after the rd handshake
    task automatic return_line(input mem_addr_t addr);
        int gap;
        for (int k = 0; k < `CACHE_BANKS; k++) begin
            gap = $random(seed) & 3;
            if (gap != 0) begin
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            ret_valid <= 1'b1;
            ret_last  <= (k == `CACHE_BANKS - 1);
            ret_data  <= mem_word({addr[31:4], bank_sel_t'(k), 2'b00});
            @(posedge clk);
        end
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            wr_rdy <= 1'b0;
            rd_rdy <= 1'b0;
        end else begin
            wr_rdy <= ($random(seed) & 3) == 0;   // random back-pressure
            rd_rdy <= ($random(seed) & 3) != 3;
        end
    end

    always @(posedge clk) begin
        if (resetn && wr_req) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                mem[{wr_addr[31:4], bank_sel_t'(b), 2'b00}] = wr_data[b*`WORD_W +: `WORD_W];
            end
        end
    end

    always @(posedge clk) begin
        if (resetn && rd_req && rd_rdy) begin
            return_line(rd_addr);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        seed      = 32'h6165;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            if (($random(seed) & 7) == 0) begin
                valid <= 1'b0;   // occasional bubble
                @(posedge clk);
            end
            r = $random(seed);
            valid  <= 1'b1;
            op     <= (r[3:0] < 4'd6);
            tag    <= 20'hc0000 | tag_t'(r[5:4]);   // four tags over four sets
            index  <= index_t'(r[7:6]);
            offset <= {r[9:8], 2'b00};
            wstrb  <= r[13:10];
            wdata  <= $random(seed);
            @(posedge clk);
            while (!addr_ok) @(posedge clk);
        end
        valid <= 1'b0;
        @(negedge clk);
        while (pending != 0) @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/cache_pkg.sv
src/cache_ctrl.sv
src/cache_store_buffer.sv
src/cache_bank_arbiter.sv
src/cache_arrays.sv
src/cache_top.sv
dv/cache_checker.sv
dv/tb_cache.sv

// File: src/cache_arrays.sv
`include "cache_defs.svh"

module cache_arrays
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  bank_access_t bank_access [2][`CACHE_BANKS],
    input  index_t       meta_index,
    input  logic [1:0]   tagv_wen,
    input  tagv_t        tagv_wdata,
    input  logic [1:0]   dirty_wen,
    input  logic         dirty_wdata,
    input  index_t       dirty_index,
    output tagv_t        way_tagv [2],
    output logic [1:0]   way_dirty,
    output word_t        way_words [2][`CACHE_BANKS]
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tagv_t                  tagv_mem [`CACHE_SETS];
        tagv_t                  tagv_q;
        logic [`CACHE_SETS-1:0] dirty_bits;

        // tag/valid, cleared on reset
        always_ff @(posedge clk) begin
            if (!resetn) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    tagv_mem[s] <= '0;
                end
            end else if (tagv_wen[w]) begin
                tagv_mem[meta_index] <= tagv_wdata;
            end
        end

        always_ff @(posedge clk) begin
            tagv_q <= tagv_mem[meta_index];   // synchronous read
        end

        assign way_tagv[w] = tagv_q;

        always_ff @(posedge clk) begin
            if (!resetn) begin
                dirty_bits <= '0;
            end else if (dirty_wen[w]) begin
                dirty_bits[dirty_index] <= dirty_wdata;
            end
        end

        assign way_dirty[w] = dirty_bits[dirty_index];

        // one word-wide bank per line word
        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            word_t        mem [`CACHE_SETS];
            word_t        rd_q;
            bank_access_t acc;

            assign acc = bank_access[w][b];

            always_ff @(posedge clk) begin
                for (int k = 0; k < 4; k++) begin
                    if (acc.wen[k]) begin
                        mem[acc.index][8*k +: 8] <= acc.wdata[8*k +: 8];
                    end
                end
                rd_q <= mem[acc.index];   // old data on a same-cycle write
            end

            assign way_words[w][b] = rd_q;
        end
    end

endmodule

// File: src/cache_bank_arbiter.sv
`include "cache_defs.svh"

module cache_bank_arbiter
    import cache_pkg::*;
(
    input  logic         busy,
    input  store_entry_t entry,
    input  bank_access_t ctrl_access [`CACHE_BANKS],
    input  way_t         ctrl_way,    // refill target way
    output bank_access_t bank_access [2][`CACHE_BANKS]
);

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                if (busy && entry.way == way_t'(w) && entry.bank == bank_sel_t'(b)) begin
                    // store buffer owns this bank for one cycle
                    bank_access[w][b].wen   = entry.wstrb;
                    bank_access[w][b].index = entry.index;
                    bank_access[w][b].wdata = entry.wdata;
                end else begin
                    bank_access[w][b].index = ctrl_access[b].index;
                    bank_access[w][b].wdata = ctrl_access[b].wdata;
                    bank_access[w][b].wen   = (ctrl_way == way_t'(w))
                                              ? ctrl_access[b].wen : 4'h0;
                end
            end
        end
    end

endmodule

// File: src/cache_ctrl.sv
`include "cache_defs.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  cpu_req_t     req,
    input  logic         conflict,
    input  tagv_t        way_tagv [2],
    input  logic [1:0]   way_dirty,
    input  word_t        way_words [2][`CACHE_BANKS],
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  word_t        ret_data,
    input  logic         wr_rdy,
    output logic         addr_ok,
    output logic         data_ok,
    output word_t        rdata,
    output logic         store_hit,
    output way_t         hit_way,
    output cpu_req_t     held_req,
    output bank_access_t ctrl_access [`CACHE_BANKS],
    output index_t       meta_index,
    output logic [1:0]   tagv_wen,
    output tagv_t        tagv_wdata,
    output logic [1:0]   dirty_wen,
    output logic         dirty_wdata,
    output logic         rd_req,
    output mem_addr_t    rd_addr,
    output logic         wr_req,
    output mem_addr_t    wr_addr,
    output line_t        wr_data
);

    main_state_e state;
    main_state_e state_nxt;
    logic [1:0]  way_hit;
    logic        cache_hit;
    way_t        hit_idx;
    way_t        victim;
    bank_sel_t   held_bank;
    bank_sel_t   refill_cnt;
    logic [7:0]  lfsr;
    logic        first_replace;   // first cycle of REPLACE
    logic        refill_beat;
    logic        refill_done;
    logic [31:0] strb_mask;
    word_t       fill_word;
    index_t      look_index;

    assign held_bank = held_req.offset[3:2];

    // tag compare against the registered request
    assign way_hit[0] = way_tagv[0].valid && (way_tagv[0].tag == held_req.tag);
    assign way_hit[1] = way_tagv[1].valid && (way_tagv[1].tag == held_req.tag);
    assign cache_hit  = |way_hit;
    assign hit_idx    = way_hit[1];

    assign victim      = lfsr[0];
    assign refill_beat = (state == REFILL) && ret_valid;
    assign refill_done = refill_beat && ret_last;

    assign addr_ok   = valid && !conflict
                       && ((state == IDLE) || (state == LOOKUP && cache_hit));
    assign store_hit = (state == LOOKUP) && cache_hit && held_req.op;
    assign data_ok   = ((state == LOOKUP) && (cache_hit || held_req.op))
                       || (refill_beat && !held_req.op && refill_cnt == held_bank);
    assign rdata     = (state == LOOKUP) ? way_words[hit_idx][held_bank] : ret_data;

    // refill writes go to the victim, lookups report the hitting way
    assign hit_way = (state == REFILL) ? victim : hit_idx;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (addr_ok) state_nxt = LOOKUP;
            LOOKUP: begin
                if (!cache_hit) begin
                    state_nxt = MISS;
                end else if (!addr_ok) begin
                    state_nxt = IDLE;
                end
            end
            MISS:    if (wr_rdy) state_nxt = REPLACE;
            REPLACE: if (rd_rdy) state_nxt = REFILL;
            REFILL:  if (refill_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            held_req <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt    <= '0;
            lfsr          <= `LFSR_SEED;
            first_replace <= 1'b0;
        end else begin
            if (refill_beat) begin
                refill_cnt <= refill_cnt + 2'd1;   // wraps after the last beat
            end
            if (refill_done) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
            first_replace <= (state == MISS) && wr_rdy;
        end
    end

    // new index while accepting, held index during the miss walk
    assign look_index = (state == IDLE || state == LOOKUP) ? req.index : held_req.index;
    assign meta_index = look_index;

    assign strb_mask = {{8{held_req.wstrb[3]}}, {8{held_req.wstrb[2]}},
                        {8{held_req.wstrb[1]}}, {8{held_req.wstrb[0]}}};
    assign fill_word = (held_req.op && refill_cnt == held_bank)
                       ? ((held_req.wdata & strb_mask) | (ret_data & ~strb_mask))
                       : ret_data;

    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            ctrl_access[b].index = look_index;
            ctrl_access[b].wdata = fill_word;
            ctrl_access[b].wen   = (refill_beat && refill_cnt == bank_sel_t'(b)) ? 4'hf : 4'h0;
        end
    end

    // tag/valid and dirty updates at the end of a refill
    assign tagv_wen    = refill_done ? (2'b01 << victim) : 2'b00;
    assign tagv_wdata  = '{tag: held_req.tag, valid: 1'b1};
    assign dirty_wen   = store_hit ? (2'b01 << hit_idx) : tagv_wen;
    assign dirty_wdata = held_req.op;   // store miss leaves the line dirty

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {held_req.tag, held_req.index, {`OFFSET_W{1'b0}}};

    // victim data is read at the held index during MISS
    assign wr_req  = first_replace && way_tagv[victim].valid && way_dirty[victim];
    assign wr_addr = {way_tagv[victim].tag, held_req.index, {`OFFSET_W{1'b0}}};

    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            wr_data[b*`WORD_W +: `WORD_W] = way_words[victim][b];
        end
    end

endmodule

// File: src/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_SETS   256
`define CACHE_BANKS  4       // 32-bit words per line
`define WORD_W       32

// address split, tag | index | byte offset
`define TAG_W        20
`define INDEX_W      8
`define OFFSET_W     4

// way choice register, must not be zero
`define LFSR_SEED    8'h01

`endif

// File: src/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0]                 word_t;
    typedef logic [`TAG_W-1:0]                  tag_t;
    typedef logic [`INDEX_W-1:0]                index_t;
    typedef logic [`OFFSET_W-1:0]               offset_t;
    typedef logic [1:0]                         bank_sel_t;   // word within a line
    typedef logic [3:0]                         strb_t;
    typedef logic                               way_t;
    typedef logic [`CACHE_BANKS*`WORD_W-1:0]    line_t;
    typedef logic [`TAG_W+`INDEX_W+`OFFSET_W-1:0] mem_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_e;

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } store_state_e;

    typedef struct packed {
        logic    op;       // 1 = store
        index_t  index;
        tag_t    tag;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        strb_t   wen;
        index_t  index;
        word_t   wdata;
    } bank_access_t;

    typedef struct packed {
        way_t      way;
        index_t    index;
        bank_sel_t bank;
        strb_t     wstrb;
        word_t     wdata;
    } store_entry_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

endpackage

// File: src/cache_store_buffer.sv
module cache_store_buffer
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         store_hit,
    input  way_t         hit_way,
    input  cpu_req_t     held_req,
    input  cpu_req_t     req,
    input  logic         valid,
    output logic         busy,
    output store_entry_t entry,
    output logic         conflict
);

    store_state_e state;
    logic         bank_clash;
    logic         word_clash;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= store_hit ? ST_WRITE : ST_IDLE;   // stays busy on back-to-back hits
        end
    end

    assign busy = (state == ST_WRITE);

    always_ff @(posedge clk) begin
        if (store_hit) begin
            entry.way   <= hit_way;
            entry.index <= held_req.index;
            entry.bank  <= held_req.offset[3:2];
            entry.wstrb <= held_req.wstrb;
            entry.wdata <= held_req.wdata;
        end
    end

    // load would read the bank being written this cycle
    assign bank_clash = busy && (req.offset[3:2] == entry.bank);
    // load of the very word the hitting store is about to write
    assign word_clash = store_hit
                        && {req.tag, req.index, req.offset[3:2]}
                           == {held_req.tag, held_req.index, held_req.offset[3:2]};

    assign conflict = valid && !req.op && (bank_clash || word_clash);

endmodule

// File: src/cache_top.sv
`include "cache_defs.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  logic      op,
    input  index_t    index,
    input  tag_t      tag,
    input  offset_t   offset,
    input  strb_t     wstrb,
    input  word_t     wdata,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    output logic      rd_req,
    output mem_addr_t rd_addr,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    output logic      wr_req,
    output mem_addr_t wr_addr,
    output line_t     wr_data,
    input  logic      wr_rdy
);

    cpu_req_t     req;
    cpu_req_t     held_req;
    logic         conflict;
    logic         store_hit;
    way_t         hit_way;
    logic         busy;
    store_entry_t entry;
    bank_access_t ctrl_access [`CACHE_BANKS];
    bank_access_t bank_access [2][`CACHE_BANKS];
    index_t       meta_index;
    logic [1:0]   tagv_wen;
    tagv_t        tagv_wdata;
    logic [1:0]   dirty_wen;
    logic         dirty_wdata;
    tagv_t        way_tagv [2];
    logic [1:0]   way_dirty;
    word_t        way_words [2][`CACHE_BANKS];

    assign req = '{op: op, index: index, tag: tag, offset: offset, wstrb: wstrb, wdata: wdata};

    cache_ctrl u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .conflict    (conflict),
        .way_tagv    (way_tagv),
        .way_dirty   (way_dirty),
        .way_words   (way_words),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_rdy      (wr_rdy),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .store_hit   (store_hit),
        .hit_way     (hit_way),
        .held_req    (held_req),
        .ctrl_access (ctrl_access),
        .meta_index  (meta_index),
        .tagv_wen    (tagv_wen),
        .tagv_wdata  (tagv_wdata),
        .dirty_wen   (dirty_wen),
        .dirty_wdata (dirty_wdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    cache_store_buffer u_store_buffer (
        .clk       (clk),
        .resetn    (resetn),
        .store_hit (store_hit),
        .hit_way   (hit_way),
        .held_req  (held_req),
        .req       (req),
        .valid     (valid),
        .busy      (busy),
        .entry     (entry),
        .conflict  (conflict)
    );

    cache_bank_arbiter u_bank_arbiter (
        .busy        (busy),
        .entry       (entry),
        .ctrl_access (ctrl_access),
        .ctrl_way    (hit_way),     // victim way while refilling
        .bank_access (bank_access)
    );

    cache_arrays u_arrays (
        .clk         (clk),
        .resetn      (resetn),
        .bank_access (bank_access),
        .meta_index  (meta_index),
        .tagv_wen    (tagv_wen),
        .tagv_wdata  (tagv_wdata),
        .dirty_wen   (dirty_wen),
        .dirty_wdata (dirty_wdata),
        .dirty_index (held_req.index),
        .way_tagv    (way_tagv),
        .way_dirty   (way_dirty),
        .way_words   (way_words)
    );

endmodule
